// File: source/led_color_pkg.sv
// ************************************************
// duty, color and palette definitions for the LED core
// duty width also sets the PWM frame length (2**DUTY_W ticks)
// palette is fixed at build time, no runtime reload
// ************************************************

`default_nettype none

package led_color_pkg;

  // duty resolution, one frame = 256 ticks
  localparam int DUTY_W = 8;

  typedef logic [DUTY_W-1:0] duty_t;

  // one color as three duties
  typedef struct packed {
    duty_t red;
    duty_t green;
    duty_t blue;
  } rgb_t;

  // channel count and per-color index
  localparam int N_CHAN   = 3;
  localparam int CH_RED   = 0;
  localparam int CH_GREEN = 1;
  localparam int CH_BLUE  = 2;

  localparam int N_COLORS = 4;  // palette length

  // palette walked by the sequencer, entry 0 shown after reset
  localparam rgb_t PALETTE [N_COLORS] = '{
    '{red: 8'd64,  green: 8'd0,   blue: 8'd0},    // dim red
    '{red: 8'd0,   green: 8'd128, blue: 8'd0},    // half green
    '{red: 8'd0,   green: 8'd0,   blue: 8'd255},  // full blue
    '{red: 8'd32,  green: 8'd96,  blue: 8'd160}   // mixed
  };

endpackage

`default_nettype wire

// File: source/board_pkg.sv
// ************************************************
// board level pin facts for the RGB LED pads
// pin 0 has the stronger drive, so green sits there
// USB lines are held idle, the board never enumerates
// ************************************************

`default_nettype none

package board_pkg;

  localparam int N_PINS = 3;  // rgb_0 .. rgb_2

  // channel index -> board pin
  // ch0 red   -> pin 1
  // ch1 green -> pin 0 (needs more current)
  // ch2 blue  -> pin 2
  localparam int PIN_OF_CHAN [led_color_pkg::N_CHAN] = '{
    1,  // red
    0,  // green
    2   // blue
  };

  // level driven onto usb_dp, usb_dn and the pull-up
  // low on all three keeps the host from seeing a device
  localparam logic USB_IDLE = 1'b0;

endpackage

`default_nettype wire

// File: source/led_bus_if.sv
// ************************************************
// shared LED timing and PWM bus, all signals on clk
// no handshake, every consumer is always ready
// one driver per signal, fixed by the modports
// ************************************************

`timescale 1ns/1ps
`default_nettype none

interface led_bus_if;
  import led_color_pkg::*;

  logic  tick;              // one-cycle enable per prescale period
  duty_t frame_cnt;         // shared frame position
  logic  frame_start;       // tick with frame_cnt at 255
  duty_t duty [N_CHAN];     // per-channel duty from sequencer
  logic  pwm  [N_CHAN];     // per-channel PWM level

  modport timer (output tick, output frame_cnt, output frame_start);

  modport seq (input frame_start, output duty);

  modport chan (input tick, input frame_cnt, input frame_start, input duty,
                output pwm);

  modport out (input pwm, input frame_start);

endinterface

`default_nettype wire

// File: source/pwm_tick_gen.sv
// ************************************************
// tick enable and shared PWM frame counter
// TICK_DIV must be at least 2, tick is one clk wide
// stays in the clk domain, no derived clock
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module pwm_tick_gen #(
  parameter int TICK_DIV = 1024  // clk cycles per tick
) (
  input  logic      clk,
  input  logic      rst_n,
  led_bus_if.timer  bus
);
  import led_color_pkg::*;

  localparam int DIV_W = $clog2(TICK_DIV);

  logic [DIV_W-1:0] div_cnt;    // prescaler
  logic             tick_int;
  duty_t            frm_cnt;

  // last prescale count marks the tick
  assign tick_int = (div_cnt == DIV_W'(TICK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      frm_cnt <= '0;
    end else begin
      if (tick_int) begin
        div_cnt <= '0;
        frm_cnt <= frm_cnt + 1'b1;  // wraps 255 -> 0
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign bus.tick        = tick_int;
  assign bus.frame_cnt   = frm_cnt;
  // next tick starts a frame at 0
  assign bus.frame_start = tick_int && (frm_cnt == '1);

endmodule

`default_nettype wire

// File: source/color_sequencer.sv
// ************************************************
// palette walker, one color per STEP_FRAMES frames
// steps only while run is high, holds color otherwise
// shows palette entry 0 after reset
// new duties reach the channels at the next frame start
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module color_sequencer #(
  parameter int STEP_FRAMES = 64  // frames per color
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run,   // level, advance enable
  led_bus_if.seq   bus
);
  import led_color_pkg::*;

  localparam int IDX_W = $clog2(N_COLORS);
  localparam int FRM_W = $clog2(STEP_FRAMES + 1);

  logic [IDX_W-1:0] color_idx;
  logic [FRM_W-1:0] frame_q;     // frames spent on current color
  logic             last_frame;
  rgb_t             cur_color;

  assign last_frame = (frame_q == FRM_W'(STEP_FRAMES - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      color_idx <= '0;
      frame_q   <= '0;
    end else if (bus.frame_start && run) begin
      if (last_frame) begin
        frame_q <= '0;
        // modulo N_COLORS, no power of two assumed
        if (color_idx == IDX_W'(N_COLORS - 1)) begin
          color_idx <= '0;
        end else begin
          color_idx <= color_idx + 1'b1;
        end
      end else begin
        frame_q <= frame_q + 1'b1;
      end
    end
  end

  // palette lookup, idx only moves on frame_start
  assign cur_color = PALETTE[color_idx];

  assign bus.duty[CH_RED]   = cur_color.red;
  assign bus.duty[CH_GREEN] = cur_color.green;
  assign bus.duty[CH_BLUE]  = cur_color.blue;

endmodule

`default_nettype wire

// File: source/pwm_channel.sv
// ************************************************
// single PWM channel on the shared frame counter
// duty is sampled on frame_start, constant per frame
// output is high for duty ticks out of 256
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module pwm_channel #(
  parameter int CHAN = 0  // which duty / pwm slot
) (
  input  logic     clk,
  input  logic     rst_n,
  led_bus_if.chan  bus
);
  import led_color_pkg::*;

  duty_t duty_q;  // duty for the running frame
  logic  pwm_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty_q <= '0;
      pwm_q  <= 1'b0;
    end else begin
      if (bus.frame_start) duty_q <= bus.duty[CHAN];
      // compare on tick only, holds between ticks
      if (bus.tick) pwm_q <= (bus.frame_cnt < duty_q);
    end
  end

  assign bus.pwm[CHAN] = pwm_q;

endmodule

`default_nettype wire

// File: source/led_output_stage.sv
// ************************************************
// LED pin stage, registered one cycle after pwm
// pins stay off until the first frame_start after reset
// blank forces all pins off on the next clk edge
// LED_ACTIVE_LOW inverts every pin, off level included
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module led_output_stage #(
  parameter bit LED_ACTIVE_LOW = 1'b0
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    blank,   // force all off
  led_bus_if.out  bus,
  output logic    rgb_0,
  output logic    rgb_1,
  output logic    rgb_2
);
  import led_color_pkg::*;
  import board_pkg::*;

  localparam logic [N_PINS-1:0] OFF_LVL = {N_PINS{LED_ACTIVE_LOW}};

  logic              armed;    // first frame seen
  logic [N_PINS-1:0] pin_lvl;  // active-high, pin order
  logic [N_PINS-1:0] pin_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) armed <= 1'b0;
    else if (bus.frame_start) armed <= 1'b1;
  end

  // gate and route channels to pins
  always_comb begin
    pin_lvl = '0;
    for (int c = 0; c < N_CHAN; c++) begin
      pin_lvl[PIN_OF_CHAN[c]] = bus.pwm[c] & armed & ~blank;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pin_q <= OFF_LVL;
    else        pin_q <= pin_lvl ^ OFF_LVL;  // polarity
  end

  assign rgb_0 = pin_q[0];
  assign rgb_1 = pin_q[1];
  assign rgb_2 = pin_q[2];

endmodule

`default_nettype wire

// File: source/rgb_blink_top.sv
// ************************************************
// portable RGB blink core, raw PWM on rgb_0..rgb_2
// no LED current driver or global buffer inside
// single clock clk, pacing done with an enable
// USB pins tied low so no host ever sees a device
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module rgb_blink_top #(
  parameter int TICK_DIV       = 1024,  // clk per tick, >= 2
  parameter int STEP_FRAMES    = 64,    // frames per color
  parameter bit LED_ACTIVE_LOW = 1'b0
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,        // palette advance enable
  input  logic blank,      // all LEDs off

  output logic rgb_0,      // LED pin 0, green
  output logic rgb_1,      // LED pin 1, red
  output logic rgb_2,      // LED pin 2, blue

  output logic usb_dp,     // USB D+
  output logic usb_dn,     // USB D-
  output logic usb_dp_pu   // USB D+ pull-up
);
  import led_color_pkg::*;
  import board_pkg::*;

  led_bus_if bus ();

  // tick and frame timing
  pwm_tick_gen #(
    .TICK_DIV(TICK_DIV)
  ) u_tick (
    .clk  (clk),
    .rst_n(rst_n),
    .bus  (bus.timer)
  );

  color_sequencer #(
    .STEP_FRAMES(STEP_FRAMES)
  ) u_seq (
    .clk  (clk),
    .rst_n(rst_n),
    .run  (run),
    .bus  (bus.seq)
  );

  // one channel per color
  for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
    pwm_channel #(
      .CHAN(c)
    ) u_chan (
      .clk  (clk),
      .rst_n(rst_n),
      .bus  (bus.chan)
    );
  end

  led_output_stage #(
    .LED_ACTIVE_LOW(LED_ACTIVE_LOW)
  ) u_out (
    .clk  (clk),
    .rst_n(rst_n),
    .blank(blank),
    .bus  (bus.out),
    .rgb_0(rgb_0),
    .rgb_1(rgb_1),
    .rgb_2(rgb_2)
  );

  // keep the host from trying to enumerate us, there is no USB stack
  assign usb_dp    = USB_IDLE;
  assign usb_dn    = USB_IDLE;
  assign usb_dp_pu = USB_IDLE;

endmodule

`default_nettype wire

// File: sim/tb_rgb_blink.sv
// ************************************************
// directed testbench for rgb_blink_top
// runs with TICK_DIV 2, so one PWM frame is 512 clk
// high counts are taken over 512 cycles with run low,
// duty must be steady across that window
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_rgb_blink;
  import led_color_pkg::*;
  import board_pkg::*;

  localparam int TICK_DIV    = 2;
  localparam int STEP_FRAMES = 2;
  localparam int CLK_PERIOD  = 8;
  localparam int FRAME_CYC   = 256 * TICK_DIV;  // clk per PWM frame
  // reset 1, duty 3, palette 15, blank 2, wrap 16
  localparam int TEST_FRAMES = 37;
  localparam int WATCHDOG_NS = (TEST_FRAMES + 4) * FRAME_CYC * CLK_PERIOD;

  logic clk = 1'b0;
  logic rst_n;
  logic run;
  logic blank;
  logic rgb_0, rgb_1, rgb_2;
  logic usb_dp, usb_dn, usb_dp_pu;
  logic usb_bad = 1'b0;  // sticky, any non-idle USB level seen

  int err_cnt = 0;
  int n_pass  = 0;
  int n_fail  = 0;

  rgb_blink_top #(
    .TICK_DIV      (TICK_DIV),
    .STEP_FRAMES   (STEP_FRAMES),
    .LED_ACTIVE_LOW(1'b0)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .blank    (blank),
    .rgb_0    (rgb_0),
    .rgb_1    (rgb_1),
    .rgb_2    (rgb_2),
    .usb_dp   (usb_dp),
    .usb_dn   (usb_dn),
    .usb_dp_pu(usb_dp_pu)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // USB lines watched over the whole run
  always @(negedge clk) begin
    if ({usb_dp, usb_dn, usb_dp_pu} !== 3'b000) usb_bad = 1'b1;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

  // 4-state compare, X or Z on got counts as a mismatch
  task automatic check(input integer got, input integer exp, input string msg);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // high cycles per pin from palette, pin map and duty x TICK_DIV
  function automatic int expected_count(input int entry, input int pin);
    rgb_t col;
    int   duty;
    col  = PALETTE[entry];
    duty = 0;
    for (int c = 0; c < N_CHAN; c++) begin
      if (PIN_OF_CHAN[c] == pin) begin
        case (c)
          CH_RED:   duty = col.red;
          CH_GREEN: duty = col.green;
          default:  duty = col.blue;
        endcase
      end
    end
    return duty * TICK_DIV;
  endfunction

  // one frame worth of samples, taken on falling edges
  task automatic measure_frame(output integer c0, output integer c1, output integer c2);
    c0 = 0;
    c1 = 0;
    c2 = 0;
    repeat (FRAME_CYC) begin
      @(negedge clk);
      c0 += rgb_0;
      c1 += rgb_1;
      c2 += rgb_2;
    end
  endtask

  task automatic check_color(input int entry);
    integer c0, c1, c2;
    measure_frame(c0, c1, c2);
    check(c0, expected_count(entry, 0), $sformatf("entry %0d rgb_0 high cycles", entry));
    check(c1, expected_count(entry, 1), $sformatf("entry %0d rgb_1 high cycles", entry));
    check(c2, expected_count(entry, 2), $sformatf("entry %0d rgb_2 high cycles", entry));
  endtask

  // run high for exactly frames frame starts, then frozen again
  task automatic run_frames(input int frames);
    run = 1'b1;
    repeat (frames * FRAME_CYC) @(negedge clk);
    run = 1'b0;
    repeat (2 * FRAME_CYC) @(negedge clk);  // new duty latched, one full frame
  endtask

  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    repeat (5) begin
      @(negedge clk);
      check({rgb_2, rgb_1, rgb_0}, 0, "pins during reset");
      check({usb_dp, usb_dn, usb_dp_pu}, 0, "usb during reset");
    end
    rst_n = 1'b1;
    // first frame start comes 512 cycles after release
    repeat (FRAME_CYC - 12) begin
      @(negedge clk);
      check({rgb_2, rgb_1, rgb_0}, 0, "pins before first frame");
      check({usb_dp, usb_dn, usb_dp_pu}, 0, "usb after reset");
    end
    finish_test("reset", e0);
  endtask

  task automatic test_duty();
    int e0;
    e0 = err_cnt;
    repeat (2 * FRAME_CYC) @(negedge clk);
    check_color(0);
    finish_test("duty", e0);
  endtask

  task automatic test_palette();
    int e0;
    e0 = err_cnt;
    for (int k = 1; k < N_COLORS; k++) begin
      run_frames(STEP_FRAMES);
      check_color(k);
    end
    finish_test("palette", e0);
  endtask

  task automatic test_blank();
    int     e0;
    integer c0, c1, c2;
    e0    = err_cnt;
    blank = 1'b1;
    measure_frame(c0, c1, c2);
    check(c0 + c1 + c2, 0, "high cycles while blanked");
    blank = 1'b0;
    repeat (4) @(negedge clk);
    check_color(N_COLORS - 1);  // still on last entry
    finish_test("blank", e0);
  endtask

  task automatic test_wrap();
    int e0;
    e0 = err_cnt;
    run_frames(STEP_FRAMES);  // last entry back to 0
    check_color(0);
    run_frames(N_COLORS * STEP_FRAMES);  // full lap
    check_color(0);
    check(usb_bad, 0, "usb left idle level");
    finish_test("wrap", e0);
  endtask

  initial begin
    rst_n = 1'b0;
    run   = 1'b0;
    blank = 1'b0;
    test_reset();
    test_duty();
    test_palette();
    test_blank();
    test_wrap();
    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
source/led_color_pkg.sv
source/board_pkg.sv
source/led_bus_if.sv
source/pwm_tick_gen.sv
source/color_sequencer.sv
source/pwm_channel.sv
source/led_output_stage.sv
source/rgb_blink_top.sv
sim/tb_rgb_blink.sv
